// File: include/transposer_settings.svh
`ifndef TRANSPOSER_SETTINGS_SVH
`define TRANSPOSER_SETTINGS_SVH

// memory address width
`define TRP_AW 16

// byte lanes per memory word, also rows per tile
`define TRP_LANES 8

// bits per lane
`define TRP_LANE_W 8

`endif

// File: design/transposer_pkg.sv
`include "transposer_settings.svh"

package transposer_pkg;

    typedef logic [`TRP_AW-1:0] addr_t;

    typedef logic [`TRP_LANES*`TRP_LANE_W-1:0] word_t;

    // row or column inside a tile
    typedef logic [$clog2(`TRP_LANES)-1:0] lane_idx_t;

    typedef enum logic [2:0] {
        FETCH_IDLE,
        FETCH_WAIT_BUF,
        FETCH_ISSUE,
        FETCH_COLLECT,
        FETCH_COMMIT
    } fetch_state_t;

    typedef enum logic [1:0] {
        WRITE_IDLE,
        WRITE_WAIT_BUF,
        WRITE_DRAIN,
        WRITE_RELEASE
    } write_state_t;

endpackage

// File: design/tile_buf_if.sv
`timescale 1ns/1ps

interface tile_buf_if
    import transposer_pkg::*;
();

    // fill side
    logic      wr_en;
    lane_idx_t wr_row;
    word_t     wr_data;
    logic      commit;
    logic      last;

    // buffer state
    logic      full;
    logic      is_last;
    word_t     rd_data;

    // drain side
    logic      rd_en;
    lane_idx_t rd_col;
    logic      release_buf;

    modport fill (
        output wr_en, wr_row, wr_data, commit, last,
        input  full
    );

    modport store (
        input  wr_en, wr_row, wr_data, commit, last,
        input  rd_en, rd_col, release_buf,
        output full, is_last, rd_data
    );

    modport drain (
        output rd_en, rd_col, release_buf,
        input  full, is_last, rd_data
    );

endinterface

// File: design/tile_buffer.sv
`timescale 1ns/1ps
`include "transposer_settings.svh"

module tile_buffer
    import transposer_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    tile_buf_if.store bus
);

    localparam int LANES = `TRP_LANES;
    localparam int LW    = `TRP_LANE_W;

    // one word per source row of the tile
    word_t store [LANES];

    // rows land as whole words; rows never written stay zero
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int r = 0; r < LANES; r++) begin
                store[r] <= '0;
            end
        end else if (bus.release_buf) begin
            for (int r = 0; r < LANES; r++) begin
                store[r] <= '0;
            end
        end else if (bus.wr_en) begin
            store[bus.wr_row] <= bus.wr_data;
        end
    end

    // byte r of the column word comes from row r
    always_ff @(posedge clk) begin
        if (bus.rd_en) begin
            for (int r = 0; r < LANES; r++) begin
                bus.rd_data[r*LW +: LW] <= store[r][bus.rd_col*LW +: LW];
            end
        end
    end

    // tile ownership flag
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bus.full    <= 1'b0;
            bus.is_last <= 1'b0;
        end else if (bus.release_buf) begin
            bus.full    <= 1'b0;
        end else if (bus.commit) begin
            bus.full    <= 1'b1;
            bus.is_last <= bus.last;
        end
    end

    // fetcher must not overwrite a tile the writer still owns
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (!reset_n)
        bus.wr_en |-> !bus.full
    ) else $error("tile_buffer: row written while buffer is full");

    // writer must only drain a committed tile
    a_no_read_when_empty: assert property (
        @(posedge clk) disable iff (!reset_n)
        bus.rd_en |-> bus.full
    ) else $error("tile_buffer: column read while buffer is not full");

endmodule

// File: design/row_fetcher.sv
`timescale 1ns/1ps
`include "transposer_settings.svh"

module row_fetcher
    import transposer_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     start,
    input  addr_t    row_count,
    input  addr_t    raddr_base,
    input  addr_t    raddr_stride,
    input  word_t    rdata,
    input  logic     rdata_vld,
    output addr_t    raddr,
    output logic     raddr_vld,
    tile_buf_if.fill buf0,
    tile_buf_if.fill buf1
);

    fetch_state_t state;
    fetch_state_t state_nxt;

    logic      cur_buf;
    addr_t     rows_left;
    addr_t     src_addr;
    addr_t     stride_q;
    lane_idx_t issue_idx;
    lane_idx_t ret_idx;
    lane_idx_t tile_last;
    logic      cur_full;
    logic      bufs_empty;
    logic      last_tile;
    logic      start_ok;

    assign cur_full   = cur_buf ? buf1.full : buf0.full;
    // a full buffer means the writer still has work from the last run
    assign bufs_empty = !buf0.full && !buf1.full;
    assign start_ok   = (state == FETCH_IDLE) && start && bufs_empty;

    // short final tile when fewer than a full tile of rows remain
    assign last_tile = rows_left <= addr_t'(`TRP_LANES);
    assign tile_last = last_tile ? lane_idx_t'(rows_left - 1'b1)
                                 : lane_idx_t'(`TRP_LANES - 1);

    always_comb begin
        state_nxt = state;
        case (state)
            FETCH_IDLE: begin
                if (start_ok) state_nxt = FETCH_WAIT_BUF;
            end
            FETCH_WAIT_BUF: begin
                if (!cur_full) state_nxt = FETCH_ISSUE;
            end
            FETCH_ISSUE: begin
                if (issue_idx == tile_last) state_nxt = FETCH_COLLECT;
            end
            FETCH_COLLECT: begin
                if (rdata_vld && ret_idx == tile_last) state_nxt = FETCH_COMMIT;
            end
            FETCH_COMMIT: begin
                state_nxt = last_tile ? FETCH_IDLE : FETCH_WAIT_BUF;
            end
            default: state_nxt = FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= FETCH_IDLE;
            cur_buf   <= 1'b0;
            rows_left <= '0;
            src_addr  <= '0;
            issue_idx <= '0;
            ret_idx   <= '0;
        end else begin
            state <= state_nxt;
            if (start_ok) begin
                cur_buf   <= 1'b0;
                rows_left <= row_count;
                src_addr  <= raddr_base;
            end
            if (rdata_vld) ret_idx <= ret_idx + 1'b1;
            if (state == FETCH_WAIT_BUF) begin
                issue_idx <= '0;
                ret_idx   <= '0;
            end
            // global row address keeps running across tiles
            if (state == FETCH_ISSUE) begin
                issue_idx <= issue_idx + 1'b1;
                src_addr  <= src_addr + stride_q;
            end
            if (state == FETCH_COMMIT) begin
                rows_left <= last_tile ? '0 : rows_left - addr_t'(`TRP_LANES);
                cur_buf   <= !cur_buf;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) stride_q <= raddr_stride;
    end

    // read request port
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) raddr_vld <= 1'b0;
        else          raddr_vld <= state == FETCH_ISSUE;
    end

    always_ff @(posedge clk) begin
        if (state == FETCH_ISSUE) raddr <= src_addr;
    end

    // in-order returns make the return count the row slot
    assign buf0.wr_en   = rdata_vld && !cur_buf;
    assign buf1.wr_en   = rdata_vld && cur_buf;
    assign buf0.wr_row  = ret_idx;
    assign buf1.wr_row  = ret_idx;
    assign buf0.wr_data = rdata;
    assign buf1.wr_data = rdata;
    assign buf0.commit  = (state == FETCH_COMMIT) && !cur_buf;
    assign buf1.commit  = (state == FETCH_COMMIT) && cur_buf;
    assign buf0.last    = last_tile;
    assign buf1.last    = last_tile;

    // requests only go out for a tile whose buffer is free
    a_vld_into_free_buf: assert property (
        @(posedge clk) disable iff (!reset_n)
        raddr_vld |-> !cur_full
    ) else $error("row_fetcher: read issued while the target buffer is full");

endmodule

// File: design/column_writer.sv
`timescale 1ns/1ps

module column_writer
    import transposer_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      start,
    input  addr_t     col_count,
    input  addr_t     waddr_base,
    input  addr_t     waddr_stride,
    output addr_t     waddr,
    output word_t     wdata,
    output logic      wdata_vld,
    output logic      finish,
    tile_buf_if.drain buf0,
    tile_buf_if.drain buf1
);

    write_state_t state;
    write_state_t state_nxt;

    logic      cur_buf;
    lane_idx_t col;
    lane_idx_t col_last;
    addr_t     tile_idx;
    addr_t     col_off;
    addr_t     base_q;
    addr_t     stride_q;
    logic      cur_full;
    logic      cur_is_last;
    logic      start_ok;
    logic      rd_fire;

    // pipeline alongside the buffer read
    logic      sel_d1;
    logic      vld_d1;
    addr_t     addr_d1;
    logic      fin_d1;

    assign cur_full    = cur_buf ? buf1.full : buf0.full;
    assign cur_is_last = cur_buf ? buf1.is_last : buf0.is_last;
    assign start_ok    = (state == WRITE_IDLE) && start;
    assign rd_fire     = state == WRITE_DRAIN;

    always_comb begin
        state_nxt = state;
        case (state)
            WRITE_IDLE: begin
                if (start) state_nxt = WRITE_WAIT_BUF;
            end
            WRITE_WAIT_BUF: begin
                if (cur_full) state_nxt = WRITE_DRAIN;
            end
            WRITE_DRAIN: begin
                if (col == col_last) state_nxt = WRITE_RELEASE;
            end
            WRITE_RELEASE: begin
                state_nxt = cur_is_last ? WRITE_IDLE : WRITE_WAIT_BUF;
            end
            default: state_nxt = WRITE_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= WRITE_IDLE;
            cur_buf  <= 1'b0;
            col      <= '0;
            tile_idx <= '0;
            col_off  <= '0;
        end else begin
            state <= state_nxt;
            if (start_ok) begin
                cur_buf  <= 1'b0;
                tile_idx <= '0;
            end
            if (state == WRITE_WAIT_BUF) begin
                col     <= '0;
                col_off <= '0;
            end
            if (rd_fire) begin
                col     <= col + 1'b1;
                col_off <= col_off + stride_q;
            end
            if (state == WRITE_RELEASE) begin
                cur_buf  <= !cur_buf;
                tile_idx <= tile_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            col_last <= lane_idx_t'(col_count - 1'b1);
            base_q   <= waddr_base;
            stride_q <= waddr_stride;
        end
    end

    // destination is base + col * stride + tile
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            sel_d1  <= cur_buf;
            addr_d1 <= base_q + col_off + tile_idx;
        end
        if (vld_d1) begin
            waddr <= addr_d1;
            wdata <= sel_d1 ? buf1.rd_data : buf0.rd_data;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vld_d1    <= 1'b0;
            wdata_vld <= 1'b0;
            fin_d1    <= 1'b0;
            finish    <= 1'b0;
        end else begin
            vld_d1    <= rd_fire;
            wdata_vld <= vld_d1;
            // lands one cycle after the final write beat
            fin_d1    <= (state == WRITE_RELEASE) && cur_is_last;
            finish    <= fin_d1;
        end
    end

    assign buf0.rd_en       = rd_fire && !cur_buf;
    assign buf1.rd_en       = rd_fire && cur_buf;
    assign buf0.rd_col      = col;
    assign buf1.rd_col      = col;
    assign buf0.release_buf = (state == WRITE_RELEASE) && !cur_buf;
    assign buf1.release_buf = (state == WRITE_RELEASE) && cur_buf;

    a_finish_single: assert property (
        @(posedge clk) disable iff (!reset_n)
        finish |=> !finish
    ) else $error("column_writer: finish held for more than one cycle");

endmodule

// File: design/transposer_top.sv
`timescale 1ns/1ps

module transposer_top
    import transposer_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  start,
    input  addr_t row_count,
    input  addr_t col_count,
    input  addr_t raddr_base,
    input  addr_t raddr_stride,
    input  addr_t waddr_base,
    input  addr_t waddr_stride,
    output addr_t raddr,
    output logic  raddr_vld,
    input  word_t rdata,
    input  logic  rdata_vld,
    output addr_t waddr,
    output word_t wdata,
    output logic  wdata_vld,
    output logic  finish
);

    // ping-pong tile buffers
    tile_buf_if buf0_if ();
    tile_buf_if buf1_if ();

    tile_buffer u_tile_buffer0 (
        .clk     (clk),
        .reset_n (reset_n),
        .bus     (buf0_if.store)
    );

    tile_buffer u_tile_buffer1 (
        .clk     (clk),
        .reset_n (reset_n),
        .bus     (buf1_if.store)
    );

    row_fetcher u_row_fetcher (
        .clk          (clk),
        .reset_n      (reset_n),
        .start        (start),
        .row_count    (row_count),
        .raddr_base   (raddr_base),
        .raddr_stride (raddr_stride),
        .rdata        (rdata),
        .rdata_vld    (rdata_vld),
        .raddr        (raddr),
        .raddr_vld    (raddr_vld),
        .buf0         (buf0_if.fill),
        .buf1         (buf1_if.fill)
    );

    column_writer u_column_writer (
        .clk          (clk),
        .reset_n      (reset_n),
        .start        (start),
        .col_count    (col_count),
        .waddr_base   (waddr_base),
        .waddr_stride (waddr_stride),
        .waddr        (waddr),
        .wdata        (wdata),
        .wdata_vld    (wdata_vld),
        .finish       (finish),
        .buf0         (buf0_if.drain),
        .buf1         (buf1_if.drain)
    );

endmodule

// File: bench/transposer_checker.sv
`timescale 1ns/1ps
`include "transposer_settings.svh"

module transposer_checker
    import transposer_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  start,
    input  addr_t row_count,
    input  addr_t col_count,
    input  addr_t raddr_base,
    input  addr_t raddr_stride,
    input  addr_t waddr_base,
    input  addr_t waddr_stride,
    input  addr_t raddr,
    input  logic  raddr_vld,
    input  word_t rdata,
    input  logic  rdata_vld,
    input  addr_t waddr,
    input  word_t wdata,
    input  logic  wdata_vld,
    input  logic  finish,
    output int    error_count
);

    localparam int LANES = `TRP_LANES;
    localparam int LW    = `TRP_LANE_W;

    // source rows of the current run in return order
    word_t rows_q [$];
    int    issued    = 0;
    int    beats     = 0;
    logic  active    = 1'b0;
    logic  prev_wvld = 1'b0;

    initial error_count = 0;

    function automatic int total_beats();
        int tiles;
        tiles = (int'(row_count) + LANES - 1) / LANES;
        return tiles * int'(col_count);
    endfunction

    // byte r of column c in tile t is byte c of source row t*LANES + r
    function automatic word_t column_word(input int t, input int c);
        word_t w;
        word_t row;
        int    g;
        w = '0;
        for (int r = 0; r < LANES; r++) begin
            g = t * LANES + r;
            if (g < int'(row_count) && g < rows_q.size()) begin
                row = rows_q[g];
                w[r*LW +: LW] = row[c*LW +: LW];
            end
        end
        return w;
    endfunction

    task automatic check_request();
        addr_t exp_addr;
        exp_addr = raddr_base + addr_t'(issued) * raddr_stride;
        if (issued >= int'(row_count)) begin
            $display("extra read request at %0t, run has only %0d rows", $time, row_count);
            error_count++;
        end else if (raddr !== exp_addr) begin
            $display("MISMATCH at %0t: read row %0d addr %h, expected %h",
                     $time, issued, raddr, exp_addr);
            error_count++;
        end
        issued++;
    endtask

    task automatic check_beat();
        int    t;
        int    c;
        addr_t exp_addr;
        word_t exp_data;
        if (beats >= total_beats()) begin
            $display("extra write at %0t, run expects only %0d writes", $time, total_beats());
            error_count++;
        end else begin
            t        = beats / int'(col_count);
            c        = beats % int'(col_count);
            exp_addr = waddr_base + addr_t'(c) * waddr_stride + addr_t'(t);
            exp_data = column_word(t, c);
            if (waddr !== exp_addr) begin
                $display("MISMATCH at %0t: tile %0d col %0d waddr %h, expected %h",
                         $time, t, c, waddr, exp_addr);
                error_count++;
            end
            if (wdata !== exp_data) begin
                $display("MISMATCH at %0t: tile %0d col %0d wdata %h, expected %h",
                         $time, t, c, wdata, exp_data);
                error_count++;
            end
        end
        beats++;
    endtask

    task automatic check_finish();
        if (!active) begin
            $display("finish pulse at %0t while no run is active", $time);
            error_count++;
        end else begin
            if (beats != total_beats()) begin
                $display("missing writes: finish at %0t after %0d of %0d writes",
                         $time, beats, total_beats());
                error_count++;
            end
            if (!prev_wvld) begin
                $display("finish at %0t does not follow the last write by one cycle", $time);
                error_count++;
            end
            if (issued != int'(row_count)) begin
                $display("run ended at %0t with %0d read requests, expected %0d",
                         $time, issued, row_count);
                error_count++;
            end
            active = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        if (!reset_n) begin
            active    = 1'b0;
            prev_wvld = 1'b0;
        end else begin
            // a start while busy must not open a new run
            if (start && !active) begin
                active    = 1'b1;
                rows_q.delete();
                issued    = 0;
                beats     = 0;
            end
            if (!active && (raddr_vld || wdata_vld)) begin
                $display("bus activity at %0t while no run is active", $time);
                error_count++;
            end
            if (active && rdata_vld) begin
                rows_q.push_back(rdata);
            end
            if (active && raddr_vld) check_request();
            if (active && wdata_vld) check_beat();
            if (finish) check_finish();
            prev_wvld = wdata_vld;
        end
    end

endmodule

// File: bench/tb_transposer.sv
`timescale 1ns/1ps

module tb_transposer
    import transposer_pkg::*;
();

    localparam int NUM_TESTS     = 6;
    localparam int CYCLE_TIMEOUT = 2000;

    typedef struct packed {
        addr_t rows;
        addr_t cols;
        addr_t rbase;
        addr_t rstride;
        addr_t wbase;
        addr_t wstride;
    } test_entry_t;

    test_entry_t tests [NUM_TESTS];

    logic  clk = 1'b0;
    logic  reset_n;
    logic  start;
    addr_t row_count;
    addr_t col_count;
    addr_t raddr_base;
    addr_t raddr_stride;
    addr_t waddr_base;
    addr_t waddr_stride;
    addr_t raddr;
    logic  raddr_vld;
    word_t rdata     = '0;
    logic  rdata_vld = 1'b0;
    addr_t waddr;
    word_t wdata;
    logic  wdata_vld;
    logic  finish;
    int    check_errors;
    int    timeouts;

    // memory model state
    addr_t       req_addr_q [$];
    int          req_due_q [$];
    logic [31:0] rng      = 32'h9209;
    int          cyc      = 0;
    int          last_due = 0;
    int          due;

    always #50 clk = ~clk;

    transposer_top transposer_top_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .start        (start),
        .row_count    (row_count),
        .col_count    (col_count),
        .raddr_base   (raddr_base),
        .raddr_stride (raddr_stride),
        .waddr_base   (waddr_base),
        .waddr_stride (waddr_stride),
        .raddr        (raddr),
        .raddr_vld    (raddr_vld),
        .rdata        (rdata),
        .rdata_vld    (rdata_vld),
        .waddr        (waddr),
        .wdata        (wdata),
        .wdata_vld    (wdata_vld),
        .finish       (finish)
    );

    transposer_checker checker_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .start        (start),
        .row_count    (row_count),
        .col_count    (col_count),
        .raddr_base   (raddr_base),
        .raddr_stride (raddr_stride),
        .waddr_base   (waddr_base),
        .waddr_stride (waddr_stride),
        .raddr        (raddr),
        .raddr_vld    (raddr_vld),
        .rdata        (rdata),
        .rdata_vld    (rdata_vld),
        .waddr        (waddr),
        .wdata        (wdata),
        .wdata_vld    (wdata_vld),
        .finish       (finish),
        .error_count  (check_errors)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // contents depend on every address bit
    function automatic word_t mem_word(input addr_t a);
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next(32'h9209 ^ 32'(a));
        lo = lcg_next(hi);
        return {hi, lo};
    endfunction

    // rows, cols, read base, read stride, write base, write stride
    task automatic load_tests();
        tests[0] = '{16'd8,  16'd8, 16'h0100, 16'd1, 16'h4000, 16'h0010};
        tests[1] = '{16'd5,  16'd8, 16'h0200, 16'd1, 16'h5000, 16'h0010};
        tests[2] = '{16'd20, 16'd8, 16'h0300, 16'd1, 16'h6000, 16'h0004};
        tests[3] = '{16'd11, 16'd3, 16'h0400, 16'd3, 16'h7000, 16'h0020};
        tests[4] = '{16'd1,  16'd1, 16'h0800, 16'd5, 16'h7800, 16'h0007};
        tests[5] = '{16'd17, 16'd5, 16'h0a00, 16'd2, 16'h7c00, 16'h0008};
    endtask

    // in-order returns, each 1 to 3 cycles after its request
    always @(posedge clk) begin
        #1;
        rdata_vld = 1'b0;
        if (!reset_n) begin
            req_addr_q.delete();
            req_due_q.delete();
        end else begin
            cyc++;
            if (req_due_q.size() > 0 && req_due_q[0] <= cyc) begin
                rdata     = mem_word(req_addr_q.pop_front());
                rdata_vld = 1'b1;
                void'(req_due_q.pop_front());
            end
            if (raddr_vld) begin
                rng = lcg_next(rng);
                due = cyc + 1 + int'((rng >> 16) % 3);
                if (due <= last_due) due = last_due + 1;
                last_due = due;
                req_addr_q.push_back(raddr);
                req_due_q.push_back(due);
            end
        end
    end

    task automatic run_test(input int i);
        int n;
        bit seen;
        @(posedge clk);
        #1;
        row_count    = tests[i].rows;
        col_count    = tests[i].cols;
        raddr_base   = tests[i].rbase;
        raddr_stride = tests[i].rstride;
        waddr_base   = tests[i].wbase;
        waddr_stride = tests[i].wstride;
        start        = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        // second start lands mid-run and must be ignored
        @(posedge clk);
        @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        seen = 1'b0;
        for (n = 0; n < CYCLE_TIMEOUT && !seen; n++) begin
            @(posedge clk);
            #1 seen = finish;
        end
        if (!seen) begin
            $display("timeout: test %0d gave no finish within %0d cycles", i, CYCLE_TIMEOUT);
            timeouts++;
        end
        repeat (6) @(posedge clk);
    endtask

    initial begin
        reset_n      = 1'b0;
        start        = 1'b0;
        row_count    = '0;
        col_count    = '0;
        raddr_base   = '0;
        raddr_stride = '0;
        waddr_base   = '0;
        waddr_stride = '0;
        timeouts     = 0;
        load_tests();
        repeat (5) @(posedge clk);
        #1 reset_n = 1'b1;
        // outputs must stay quiet before the first start
        repeat (4) @(posedge clk);
        for (int i = 0; i < NUM_TESTS && timeouts == 0; i++) begin
            run_test(i);
        end
        repeat (4) @(posedge clk);
        #1;
        $display("errors: %0d check, %0d timeout", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+include
design/transposer_pkg.sv
design/tile_buf_if.sv
design/tile_buffer.sv
design/row_fetcher.sv
design/column_writer.sv
design/transposer_top.sv
bench/transposer_checker.sv
bench/tb_transposer.sv
